// File: hw/isaPkg.sv
package isaPkg;

    // Width of the bus, the registers and memory words
    localparam int dataWidth = 32;
    localparam int regCount = 16;

    // Instruction field positions
    localparam int opMsb = 31;
    localparam int opLsb = 27;
    localparam int raMsb = 26;
    localparam int raLsb = 23;
    localparam int rbMsb = 22;
    localparam int rbLsb = 19;
    localparam int rcMsb = 18;
    localparam int rcLsb = 15;
    localparam int cMsb = 18;
    localparam int cLsb = 0;
    localparam int cWidth = cMsb - cLsb + 1;

    // Opcodes keep the numbering of the full teaching ISA
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opLdi  = 5'b00001,
        opSt   = 5'b00010,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opAddi = 5'b01100,
        opOut  = 5'b10111,
        opHalt = 5'b11011
    } opcodeT;

endpackage

// File: hw/ctrlPkg.sv
package ctrlPkg;

    // Sequencer steps, T7 is only used by ld
    typedef enum logic [3:0] {
        stIdle = 4'd0,
        stT0   = 4'd1,
        stT1   = 4'd2,
        stT2   = 4'd3,
        stT3   = 4'd4,
        stT4   = 4'd5,
        stT5   = 4'd6,
        stT6   = 4'd7,
        stT7   = 4'd8,
        stHalt = 4'd9
    } stepT;

    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluAnd  = 3'd2,
        aluOr   = 3'd3,
        aluPass = 3'd4
    } aluOpT;

    // One source on the bus per cycle
    typedef enum logic [2:0] {
        srcNone = 3'd0,
        srcReg  = 3'd1,
        srcPc   = 3'd2,
        srcMdr  = 3'd3,
        srcZlow = 3'd4,
        srcC    = 3'd5
    } busSrcT;

endpackage

// File: hw/regFile.sv
module regFile (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [isaPkg::dataWidth-1:0] ir,
    input  logic                         gra,
    input  logic                         grb,
    input  logic                         grc,
    input  logic                         rIn,
    input  logic                         baOut,
    input  logic [isaPkg::dataWidth-1:0] busIn,
    output logic [isaPkg::dataWidth-1:0] regOut
);

    localparam int idxWidth = $clog2(isaPkg::regCount);

    logic [isaPkg::dataWidth-1:0] regs [isaPkg::regCount];
    logic [idxWidth-1:0]          sel;

    // Select and encode from the IR fields
    always_comb begin
        if (gra) begin
            sel = ir[isaPkg::raMsb:isaPkg::raLsb];
        end else if (grb) begin
            sel = ir[isaPkg::rbMsb:isaPkg::rbLsb];
        end else if (grc) begin
            sel = ir[isaPkg::rcMsb:isaPkg::rcLsb];
        end else begin
            sel = '0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < isaPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= busIn;
        end
    end

    // R0 used as a base reads zero
    always_comb begin
        if (baOut && sel == '0) begin
            regOut = '0;
        end else begin
            regOut = regs[sel];
        end
    end

endmodule

// File: hw/alu.sv
module alu (
    input  ctrlPkg::aluOpT                 op,
    input  logic [isaPkg::dataWidth-1:0]   a,
    input  logic [isaPkg::dataWidth-1:0]   b,
    output logic [2*isaPkg::dataWidth-1:0] result
);

    logic [isaPkg::dataWidth-1:0] sum;
    logic [isaPkg::dataWidth-1:0] diff;

    assign sum  = a + b;
    assign diff = a - b;

    // Arithmetic results fill the high half with the sign
    always_comb begin
        case (op)
            ctrlPkg::aluAdd: begin
                result = {{isaPkg::dataWidth{sum[isaPkg::dataWidth-1]}}, sum};
            end
            ctrlPkg::aluSub: begin
                result = {{isaPkg::dataWidth{diff[isaPkg::dataWidth-1]}}, diff};
            end
            ctrlPkg::aluAnd: begin
                result = {{isaPkg::dataWidth{1'b0}}, a & b};
            end
            ctrlPkg::aluOr: begin
                result = {{isaPkg::dataWidth{1'b0}}, a | b};
            end
            ctrlPkg::aluPass: begin
                result = {{isaPkg::dataWidth{1'b0}}, b};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hw/mainMemory.sv
module mainMemory #(
    parameter int memAddrWidth = 9
) (
    input  logic                    clk,
    input  logic [memAddrWidth-1:0] addr,
    input  logic [31:0]             wrData,
    input  logic                    wrEn,
    output logic [31:0]             rdData,
    input  logic                    loadEn,
    input  logic [memAddrWidth-1:0] loadAddr,
    input  logic [31:0]             loadData
);

    localparam int depth = 1 << memAddrWidth;

    logic [31:0] mem [depth];

    // Program load wins over a CPU store
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end else if (wrEn) begin
            mem[addr] <= wrData;
        end
    end

    assign rdData = mem[addr];

endmodule

// File: hw/dataPath.sv
module dataPath #(
    parameter int memAddrWidth = 9
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  ctrlPkg::busSrcT              busSrc,
    input  ctrlPkg::aluOpT               aluOp,
    input  logic                         gra,
    input  logic                         grb,
    input  logic                         grc,
    input  logic                         rIn,
    input  logic                         baOut,
    input  logic                         pcIn,
    input  logic                         irIn,
    input  logic                         yIn,
    input  logic                         zIn,
    input  logic                         marIn,
    input  logic                         mdrIn,
    input  logic                         outIn,
    input  logic                         incPc,
    input  logic                         memRead,
    input  logic                         memWrite,
    input  logic                         loadEn,
    input  logic [memAddrWidth-1:0]      loadAddr,
    input  logic [isaPkg::dataWidth-1:0] loadData,
    input  logic                         runClr,
    output isaPkg::opcodeT               opcode,
    output logic [isaPkg::dataWidth-1:0] outData
);

    localparam int w = isaPkg::dataWidth;

    logic [w-1:0]            bus;
    logic [w-1:0]            pc;
    logic [w-1:0]            ir;
    logic [w-1:0]            y;
    logic [2*w-1:0]          z;
    logic [memAddrWidth-1:0] mar;
    logic [w-1:0]            mdr;
    logic [w-1:0]            outReg;
    logic [w-1:0]            regOut;
    logic [w-1:0]            cSext;
    logic [w-1:0]            aluA;
    logic [w-1:0]            aluB;
    logic [2*w-1:0]          aluResult;
    logic [w-1:0]            memRdData;

    assign cSext = {{(w - isaPkg::cWidth){ir[isaPkg::cMsb]}}, ir[isaPkg::cMsb:isaPkg::cLsb]};

    always_comb begin
        case (busSrc)
            ctrlPkg::srcReg:  bus = regOut;
            ctrlPkg::srcPc:   bus = pc;
            ctrlPkg::srcMdr:  bus = mdr;
            ctrlPkg::srcZlow: bus = z[w-1:0];
            ctrlPkg::srcC:    bus = cSext;
            default:          bus = '0;
        endcase
    end

    // PC increment goes through the ALU with Y bypassed
    assign aluA = incPc ? pc : y;
    assign aluB = incPc ? w'(1) : bus;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (runClr) begin
            pc <= '0;
        end else if (pcIn) begin
            pc <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (irIn) begin
            ir <= bus;
        end
        if (yIn) begin
            y <= bus;
        end
        if (zIn) begin
            z <= aluResult;
        end
        if (marIn) begin
            mar <= bus[memAddrWidth-1:0];
        end
        // MDR takes memory on a read, the bus otherwise
        if (mdrIn) begin
            mdr <= memRead ? memRdData : bus;
        end
        if (outIn) begin
            outReg <= bus;
        end
    end

    assign opcode  = isaPkg::opcodeT'(ir[isaPkg::opMsb:isaPkg::opLsb]);
    assign outData = outReg;

    regFile regs0 (
        .clk    (clk),
        .rstN   (rstN),
        .ir     (ir),
        .gra    (gra),
        .grb    (grb),
        .grc    (grc),
        .rIn    (rIn),
        .baOut  (baOut),
        .busIn  (bus),
        .regOut (regOut)
    );

    alu alu0 (
        .op     (aluOp),
        .a      (aluA),
        .b      (aluB),
        .result (aluResult)
    );

    mainMemory #(
        .memAddrWidth (memAddrWidth)
    ) mem0 (
        .clk      (clk),
        .addr     (mar),
        .wrData   (bus),
        .wrEn     (memWrite),
        .rdData   (memRdData),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData)
    );

endmodule

// File: hw/controlUnit.sv
module controlUnit #(
    parameter int memAddrWidth = 9
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            run,
    input  isaPkg::opcodeT  opcode,
    output ctrlPkg::busSrcT busSrc,
    output ctrlPkg::aluOpT  aluOp,
    output logic            gra,
    output logic            grb,
    output logic            grc,
    output logic            rIn,
    output logic            baOut,
    output logic            pcIn,
    output logic            irIn,
    output logic            yIn,
    output logic            zIn,
    output logic            marIn,
    output logic            mdrIn,
    output logic            outIn,
    output logic            incPc,
    output logic            memRead,
    output logic            memWrite,
    output logic            runClr,
    output logic            outValid,
    output logic            halted,
    output logic            idle
);

    ctrlPkg::stepT step;
    ctrlPkg::stepT nextStep;
    logic          isRegAlu;
    logic          isImm;
    logic          isMem;

    assign isRegAlu = opcode inside {isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr};
    assign isImm    = opcode inside {isaPkg::opAddi, isaPkg::opLdi};
    assign isMem    = opcode inside {isaPkg::opLd, isaPkg::opSt};

    always_comb begin
        case (step)
            ctrlPkg::stT0: nextStep = ctrlPkg::stT1;
            ctrlPkg::stT1: nextStep = ctrlPkg::stT2;
            ctrlPkg::stT2: nextStep = ctrlPkg::stT3;
            ctrlPkg::stT3: begin
                if (opcode == isaPkg::opHalt) begin
                    nextStep = ctrlPkg::stHalt;
                end else if (isRegAlu || isImm || isMem) begin
                    nextStep = ctrlPkg::stT4;
                end else begin
                    nextStep = ctrlPkg::stT0;
                end
            end
            ctrlPkg::stT4: nextStep = ctrlPkg::stT5;
            ctrlPkg::stT5: nextStep = isMem ? ctrlPkg::stT6 : ctrlPkg::stT0;
            ctrlPkg::stT6: nextStep = (opcode == isaPkg::opLd) ? ctrlPkg::stT7 : ctrlPkg::stT0;
            ctrlPkg::stT7: nextStep = ctrlPkg::stT0;
            default:       nextStep = step;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            step     <= ctrlPkg::stIdle;
            outValid <= 1'b0;
        end else begin
            step     <= run ? ctrlPkg::stT0 : nextStep;
            outValid <= outIn;
        end
    end

    // Strobes for the current step
    always_comb begin
        busSrc   = ctrlPkg::srcNone;
        aluOp    = ctrlPkg::aluAdd;
        gra      = 1'b0;
        grb      = 1'b0;
        grc      = 1'b0;
        rIn      = 1'b0;
        baOut    = 1'b0;
        pcIn     = 1'b0;
        irIn     = 1'b0;
        yIn      = 1'b0;
        zIn      = 1'b0;
        marIn    = 1'b0;
        mdrIn    = 1'b0;
        outIn    = 1'b0;
        incPc    = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (step)
            ctrlPkg::stT0: begin
                busSrc = ctrlPkg::srcPc;
                marIn  = 1'b1;
                incPc  = 1'b1;
                zIn    = 1'b1;
            end
            ctrlPkg::stT1: begin
                busSrc  = ctrlPkg::srcZlow;
                pcIn    = 1'b1;
                memRead = 1'b1;
                mdrIn   = 1'b1;
            end
            ctrlPkg::stT2: begin
                busSrc = ctrlPkg::srcMdr;
                irIn   = 1'b1;
            end
            ctrlPkg::stT3: begin
                if (opcode == isaPkg::opOut) begin
                    busSrc = ctrlPkg::srcReg;
                    gra    = 1'b1;
                    outIn  = 1'b1;
                end else if (isRegAlu || isImm || isMem) begin
                    busSrc = ctrlPkg::srcReg;
                    grb    = 1'b1;
                    baOut  = 1'b1;
                    yIn    = 1'b1;
                end
            end
            ctrlPkg::stT4: begin
                zIn = 1'b1;
                if (isRegAlu) begin
                    busSrc = ctrlPkg::srcReg;
                    grc    = 1'b1;
                end else begin
                    busSrc = ctrlPkg::srcC;
                end
                case (opcode)
                    isaPkg::opSub: aluOp = ctrlPkg::aluSub;
                    isaPkg::opAnd: aluOp = ctrlPkg::aluAnd;
                    isaPkg::opOr:  aluOp = ctrlPkg::aluOr;
                    default:       aluOp = ctrlPkg::aluAdd;
                endcase
            end
            ctrlPkg::stT5: begin
                busSrc = ctrlPkg::srcZlow;
                if (isMem) begin
                    marIn = 1'b1;
                end else begin
                    gra = 1'b1;
                    rIn = 1'b1;
                end
            end
            ctrlPkg::stT6: begin
                if (opcode == isaPkg::opLd) begin
                    memRead = 1'b1;
                    mdrIn   = 1'b1;
                end else begin
                    busSrc   = ctrlPkg::srcReg;
                    gra      = 1'b1;
                    memWrite = 1'b1;
                end
            end
            ctrlPkg::stT7: begin
                // Loaded word back to ra
                busSrc = ctrlPkg::srcMdr;
                gra    = 1'b1;
                rIn    = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign runClr = run;
    assign halted = step == ctrlPkg::stHalt;
    assign idle   = step == ctrlPkg::stIdle;

endmodule

// File: hw/cpuTop.sv
module cpuTop #(
    parameter int memAddrWidth = 9
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    loadEn,
    input  logic [memAddrWidth-1:0] loadAddr,
    input  logic [31:0]             loadData,
    input  logic                    run,
    output logic                    outValid,
    output logic [31:0]             outData,
    output logic                    halted
);

    ctrlPkg::busSrcT busSrc;
    ctrlPkg::aluOpT  aluOp;
    isaPkg::opcodeT  opcode;
    logic gra, grb, grc, rIn, baOut;
    logic pcIn, irIn, yIn, zIn, marIn, mdrIn, outIn, incPc;
    logic memRead, memWrite, runClr, idle;
    logic memLoad;

    // Program loads only while the machine is stopped
    assign memLoad = loadEn & (idle | halted);

    controlUnit #(
        .memAddrWidth (memAddrWidth)
    ) ctrl0 (
        .clk (clk), .rstN (rstN), .run (run), .opcode (opcode),
        .busSrc (busSrc), .aluOp (aluOp),
        .gra (gra), .grb (grb), .grc (grc), .rIn (rIn), .baOut (baOut),
        .pcIn (pcIn), .irIn (irIn), .yIn (yIn), .zIn (zIn),
        .marIn (marIn), .mdrIn (mdrIn), .outIn (outIn), .incPc (incPc),
        .memRead (memRead), .memWrite (memWrite),
        .runClr (runClr), .outValid (outValid), .halted (halted), .idle (idle)
    );

    dataPath #(
        .memAddrWidth (memAddrWidth)
    ) path0 (
        .clk (clk), .rstN (rstN), .busSrc (busSrc), .aluOp (aluOp),
        .gra (gra), .grb (grb), .grc (grc), .rIn (rIn), .baOut (baOut),
        .pcIn (pcIn), .irIn (irIn), .yIn (yIn), .zIn (zIn),
        .marIn (marIn), .mdrIn (mdrIn), .outIn (outIn), .incPc (incPc),
        .memRead (memRead), .memWrite (memWrite),
        .loadEn (memLoad), .loadAddr (loadAddr), .loadData (loadData),
        .runClr (runClr), .opcode (opcode), .outData (outData)
    );

endmodule

// File: test/cpuTb.sv
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int memAddrWidth = 9;
    localparam int clkPeriod = 10;
    localparam string traceFile = "test/program_trace.txt";

    logic                    clk;
    logic                    rstN;
    logic                    loadEn;
    logic [memAddrWidth-1:0] loadAddr;
    logic [31:0]             loadData;
    logic                    run;
    logic                    outValid;
    logic [31:0]             outData;
    logic                    halted;

    // Parsed trace records
    string       recKind [$];
    string       recText [$];
    logic [31:0] recA [$];
    logic [31:0] recB [$];
    logic [31:0] expected [$];

    int    wordCount;
    int    errors;
    int    passCount;
    int    failCount;
    int    testStartErrors;
    bit    testOpen;
    bit    traceReady;
    string testName;

    cpuTop #(
        .memAddrWidth (memAddrWidth)
    ) dut0 (
        .clk      (clk),
        .rstN     (rstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .run      (run),
        .outValid (outValid),
        .outData  (outData),
        .halted   (halted)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s got 0x%08h, expected 0x%08h", $time, name, got, exp);
            errors++;
        end
    endtask

    // 32-bit two's-complement and bitwise rules of the ISA
    function automatic logic [31:0] aluModel(input string op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            "add":   return a + b;
            "sub":   return a - b;
            "and":   return a & b;
            "or":    return a | b;
            default: return 32'hx;
        endcase
    endfunction

    task automatic readTrace();
        int          fd;
        int          n;
        int          want;
        string       tok;
        string       txt;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen(traceFile, "r");
        if (fd == 0) begin
            $display("Cannot open the trace file %s", traceFile);
            $display("Result: FAILED");
            $finish;
        end else begin
            while ($fscanf(fd, " %s", tok) == 1) begin
                txt = "";
                a = '0;
                b = '0;
                n = 0;
                want = 0;
                if (tok.substr(0, 0) == "#") begin
                    // Rest of the line is a comment
                    void'($fgets(line, fd));
                end else begin
                    if (tok == "T") begin
                        n = $fscanf(fd, " %s", txt);
                        want = 1;
                    end else if (tok == "P") begin
                        n = $fscanf(fd, " %h %h", a, b);
                        want = 2;
                        wordCount++;
                    end else if (tok == "E") begin
                        n = $fscanf(fd, " %h", a);
                        want = 1;
                    end else if (tok == "A") begin
                        n = $fscanf(fd, " %s %h %h", txt, a, b);
                        want = 3;
                        if (txt != "add" && txt != "sub" && txt != "and" && txt != "or") begin
                            $display("Trace names an unknown ALU operation %s", txt);
                            errors++;
                        end
                    end else if (tok != "R") begin
                        $display("Trace holds an unknown record type %s", tok);
                        errors++;
                    end
                    if (n != want) begin
                        $display("Trace record %s is missing some of its fields", tok);
                        errors++;
                    end
                    recKind.push_back(tok);
                    recText.push_back(txt);
                    recA.push_back(a);
                    recB.push_back(b);
                end
            end
            $fclose(fd);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic loadWord(input logic [31:0] addr, input logic [31:0] word);
        @(posedge clk);
        #1;
        loadEn   = 1'b1;
        loadAddr = addr[memAddrWidth-1:0];
        loadData = word;
        @(posedge clk);
        #1;
        loadEn = 1'b0;
    endtask

    task automatic runProgram();
        @(posedge clk);
        #1;
        run = 1'b1;
        @(posedge clk);
        #1;
        run = 1'b0;
        while (!halted) begin
            @(posedge clk);
            #1;
        end
        // A few more cycles so a stray out after halt is caught
        repeat (3) @(posedge clk);
        if (expected.size() != 0) begin
            $display("Test %s: %0d expected outputs were missing when the CPU halted",
                     testName, expected.size());
            errors++;
            expected.delete();
        end
    endtask

    task automatic finishTest();
        if (errors == testStartErrors) begin
            $display("Test %s: passed", testName);
            passCount++;
        end else begin
            $display("Test %s: failed with %0d errors", testName, errors - testStartErrors);
            failCount++;
        end
        testOpen = 1'b0;
    endtask

    // Output monitor samples away from the active edge
    always @(negedge clk) begin
        if (rstN && outValid) begin
            if (expected.size() == 0) begin
                $display("Unexpected output 0x%08h at %0d ns when no value was expected",
                         outData, $time);
                errors++;
            end else begin
                checkValue("outData", outData, expected.pop_front());
            end
        end
    end

    initial begin
        wait (traceReady);
        #((wordCount * 10 + 200) * clkPeriod);
        $display("Timeout after %0d cycles, the CPU never reached halt", wordCount * 10 + 200);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        loadEn = 1'b0;
        loadAddr = '0;
        loadData = '0;
        run = 1'b0;
        errors = 0;
        wordCount = 0;
        passCount = 0;
        failCount = 0;
        testOpen = 1'b0;
        traceReady = 1'b0;
        testName = "none";
        testStartErrors = 0;
        readTrace();
        traceReady = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        foreach (recKind[i]) begin
            case (recKind[i])
                "T": begin
                    if (testOpen) begin
                        finishTest();
                    end
                    testName = recText[i];
                    testStartErrors = errors;
                    testOpen = 1'b1;
                end
                "P": loadWord(recA[i], recB[i]);
                "E": expected.push_back(recA[i]);
                "A": expected.push_back(aluModel(recText[i], recA[i], recB[i]));
                "R": runProgram();
                default: begin
                end
            endcase
        end
        if (testOpen) begin
            finishTest();
        end
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 passCount, failCount, errors);
        if (failCount == 0 && errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: test/program_trace.txt
# Records: T name | P addr word | E value | A op a b | R  (all numbers hex)
# A queues the ALU result of a and b as the expected out value, R runs from address 0
T ldiBaseZero
P 0 08800075 # ldi r1, 0x75
P 1 b8800000 # out r1
P 2 d8000000 # halt
E 00000075
R
T ldiBaseOffset
P 0 09000064 # ldi r2, 100
P 1 0997fffc # ldi r3, -4(r2)
P 2 b9000000 # out r2
P 3 b9800000 # out r3
P 4 d8000000 # halt
E 00000064
E 00000060
R
T aluOps
P 0 08812345 # ldi r1, 0x12345
P 1 0907fcdf # ldi r2, -0x321
P 2 1a090000 # add r4, r1, r2
P 3 ba000000 # out r4
P 4 22890000 # sub r5, r1, r2
P 5 ba800000 # out r5
P 6 2b090000 # and r6, r1, r2
P 7 bb000000 # out r6
P 8 33890000 # or r7, r1, r2
P 9 bb800000 # out r7
P a 640ffffb # addi r8, r1, -5
P b bc000000 # out r8
P c 24908000 # sub r9, r2, r1
P d bc800000 # out r9
P e d8000000 # halt
A add 00012345 fffffcdf
A sub 00012345 fffffcdf
A and 00012345 fffffcdf
A or 00012345 fffffcdf
A add 00012345 fffffffb
A sub fffffcdf 00012345
R
T loadStore
P 40 cafef00d # preloaded data word
P 0 08805a5a # ldi r1, 0x5a5a
P 1 09000020 # ldi r2, 0x20
P 2 10900010 # st r1, 0x10(r2)
P 3 01900010 # ld r3, 0x10(r2)
P 4 b9800000 # out r3
P 5 02000040 # ld r4, 0x40
P 6 ba000000 # out r4
P 7 d8000000 # halt
E 00005a5a
E cafef00d
R
T haltRerun
P 0 0a800007 # ldi r5, 7
P 1 ba800000 # out r5
P 2 d8000000 # halt
P 3 ba800000 # out r5, never reached
E 00000007
R

// File: vlog.f
hw/isaPkg.sv
hw/ctrlPkg.sv
hw/regFile.sv
hw/alu.sv
hw/mainMemory.sv
hw/dataPath.sv
hw/controlUnit.sv
hw/cpuTop.sv
test/cpuTb.sv
